//--- rtl/conv_defs.svh
/*
  convolution engine parameters
  word format, vector length and operand signedness
*/
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// ====================
// word format
// ====================

// bits per fixed-point word
`define CONV_WIDTH 16

// fraction bits within a word
`define CONV_FRAC 8

// 1 for two's complement, 0 for unsigned
`define CONV_SIGNED 1

// elements per vector, one multiplier lane each
`define CONV_LENGTH 4

`endif

//--- rtl/fixed_pkg.sv
/*
  fixed-point types
  operand word and full-width product
*/
`include "conv_defs.svh"

package fixed_pkg;

  // ====================
  // word types
  // ====================

  // one operand or truncated result
  typedef logic [`CONV_WIDTH-1:0] word_t;

  // product before the fraction shift
  typedef logic [2*`CONV_WIDTH-1:0] prod_t;

endpackage

//--- rtl/conv_pkg.sv
/*
  convolution controller types
  FSM state encoding and the vector array
*/
`include "conv_defs.svh"

package conv_pkg;

  // ====================
  // controller
  // ====================

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } conv_state_t;

  // one vector, element i per lane i
  typedef fixed_pkg::word_t vec_t [`CONV_LENGTH];

endpackage

//--- rtl/mul_if.sv
/*
  multiplier lane channel
  operands with start strobe, result with valid/ready
*/
interface mul_if;

  // controller to multiplier
  logic             start;
  fixed_pkg::word_t a;
  fixed_pkg::word_t b;
  logic             res_rdy;

  // multiplier to controller
  logic             res_val;
  fixed_pkg::word_t c;

  modport ctrl (
    output start,
    output a,
    output b,
    output res_rdy,
    input  res_val,
    input  c
  );

  modport unit (
    input  start,
    input  a,
    input  b,
    input  res_rdy,
    output res_val,
    output c
  );

endinterface

//--- rtl/fixed_mul_iter.sv
/*
  iterative fixed-point multiplier
  one multiplier bit per cycle, sign restored and fraction shifted at the end
*/
`include "conv_defs.svh"

module fixed_mul_iter (
  input logic clk,
  input logic reset,
  mul_if.unit port
);

  localparam int CNT_W = $clog2(`CONV_WIDTH);

  // control
  logic [CNT_W-1:0] count;
  logic             busy;
  logic             res_val;

  // operand magnitudes and result sign at start
  fixed_pkg::word_t a_mag;
  fixed_pkg::word_t b_mag;
  logic             neg_in;

  // datapath registers
  fixed_pkg::word_t mplier;
  fixed_pkg::prod_t mcand;
  fixed_pkg::prod_t acc;
  logic             neg;
  fixed_pkg::prod_t prod;

  // ====================
  // operand conditioning
  // ====================

  always_comb begin
    if (`CONV_SIGNED != 0) begin
      a_mag  = port.a[`CONV_WIDTH-1] ? fixed_pkg::word_t'(-port.a) : port.a;
      b_mag  = port.b[`CONV_WIDTH-1] ? fixed_pkg::word_t'(-port.b) : port.b;
      neg_in = port.a[`CONV_WIDTH-1] ^ port.b[`CONV_WIDTH-1];
    end else begin
      a_mag  = port.a;
      b_mag  = port.b;
      neg_in = 1'b0;
    end
  end

  // ====================
  // control
  // ====================

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      res_val <= 1'b0;
      count   <= '0;
    end else if (port.start) begin
      busy    <= 1'b1;
      res_val <= 1'b0;
      count   <= '0;
    end else if (busy) begin
      count <= count + 1'b1;
      // last multiplier bit
      if (count == CNT_W'(`CONV_WIDTH - 1)) begin
        busy    <= 1'b0;
        res_val <= 1'b1;
      end
    end else if (res_val && port.res_rdy) begin
      res_val <= 1'b0;
    end
  end

  // ====================
  // shift and add
  // ====================

  always_ff @(posedge clk) begin
    if (port.start) begin
      mcand  <= fixed_pkg::prod_t'(a_mag);
      mplier <= b_mag;
      acc    <= '0;
      neg    <= neg_in;
    end else if (busy) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // sign back on, then drop the fraction bits and the upper half
  always_comb begin
    prod   = neg ? fixed_pkg::prod_t'(-acc) : acc;
    port.c = prod[`CONV_FRAC +: `CONV_WIDTH];
  end

  assign port.res_val = res_val;

endmodule

//--- rtl/conv_block.sv
/*
  convolution block
  accepts an input/filter pair and multiplies input[i] by filter[n-1-i] per lane
*/
`include "conv_defs.svh"

module conv_block (
  input  logic           clk,
  input  logic           reset,

  input  logic           input_val,
  output logic           input_rdy,
  input  conv_pkg::vec_t input_msg,

  input  logic           filter_val,
  output logic           filter_rdy,
  input  conv_pkg::vec_t filter_msg,

  input  logic           output_rdy,
  output logic           output_val,
  output conv_pkg::vec_t output_msg
);

  conv_pkg::conv_state_t   state;
  conv_pkg::conv_state_t   next_state;
  logic                    accept;
  logic [`CONV_LENGTH-1:0] lane_done;

  // both vectors present while idle
  assign accept = (state == conv_pkg::IDLE) && input_val && filter_val;

  // ====================
  // controller
  // ====================

  always_comb begin
    case (state)
      conv_pkg::IDLE: next_state = accept ? conv_pkg::CALC : conv_pkg::IDLE;
      conv_pkg::CALC: next_state = (&lane_done) ? conv_pkg::DONE : conv_pkg::CALC;
      conv_pkg::DONE: next_state = output_rdy ? conv_pkg::IDLE : conv_pkg::DONE;
      default:        next_state = conv_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= conv_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  // handshakes straight from the state
  always_comb begin
    input_rdy  = (state == conv_pkg::IDLE);
    filter_rdy = (state == conv_pkg::IDLE);
    output_val = (state == conv_pkg::DONE);
  end

  // ====================
  // multiplier lanes
  // ====================

  for (genvar i = 0; i < `CONV_LENGTH; i++) begin : g_lane
    mul_if lane_if ();

    // filter taken in reverse order
    assign lane_if.start   = accept;
    assign lane_if.a       = input_msg[i];
    assign lane_if.b       = filter_msg[`CONV_LENGTH-1-i];
    assign lane_if.res_rdy = output_val & output_rdy;

    assign lane_done[i]  = lane_if.res_val;
    assign output_msg[i] = lane_if.c;

    fixed_mul_iter mul_inst (
      .clk   (clk),
      .reset (reset),
      .port  (lane_if.unit)
    );
  end

endmodule

//--- rtl/conv_top.sv
/*
  convolution engine top level
  flat vector ports around the convolution block
*/
`include "conv_defs.svh"

module conv_top (
  input  logic                              clk,
  input  logic                              reset,

  input  logic                              input_val,
  output logic                              input_rdy,
  input  logic [`CONV_LENGTH*`CONV_WIDTH-1:0] input_msg,

  input  logic                              filter_val,
  output logic                              filter_rdy,
  input  logic [`CONV_LENGTH*`CONV_WIDTH-1:0] filter_msg,

  input  logic                              output_rdy,
  output logic                              output_val,
  output logic [`CONV_LENGTH*`CONV_WIDTH-1:0] output_msg
);

  conv_pkg::vec_t input_vec;
  conv_pkg::vec_t filter_vec;
  conv_pkg::vec_t output_vec;

  // element i at bits [i*W +: W]
  for (genvar i = 0; i < `CONV_LENGTH; i++) begin : g_slice
    assign input_vec[i]  = input_msg[i*`CONV_WIDTH +: `CONV_WIDTH];
    assign filter_vec[i] = filter_msg[i*`CONV_WIDTH +: `CONV_WIDTH];
    assign output_msg[i*`CONV_WIDTH +: `CONV_WIDTH] = output_vec[i];
  end

  conv_block conv_block_inst (
    .clk        (clk),
    .reset      (reset),
    .input_val  (input_val),
    .input_rdy  (input_rdy),
    .input_msg  (input_vec),
    .filter_val (filter_val),
    .filter_rdy (filter_rdy),
    .filter_msg (filter_vec),
    .output_rdy (output_rdy),
    .output_val (output_val),
    .output_msg (output_vec)
  );

endmodule

//--- bench/conv_tb.sv
/*
  convolution engine testbench
  directed table and xorshift vectors checked against a fixed-point product model
*/
`include "conv_defs.svh"

module conv_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int W       = `CONV_WIDTH;
  localparam int L       = `CONV_LENGTH;
  localparam int VW      = L * W;
  localparam int NROWS   = 6;
  localparam int NRAND   = 20;
  localparam int TIMEOUT = 100;
  localparam int LATENCY = `CONV_WIDTH + 1;

  logic          clk;
  logic          reset;
  logic          input_val;
  logic          input_rdy;
  logic [VW-1:0] input_msg;
  logic          filter_val;
  logic          filter_rdy;
  logic [VW-1:0] filter_msg;
  logic          output_rdy;
  logic          output_val;
  logic [VW-1:0] output_msg;

  logic [VW-1:0] tbl_in  [NROWS];
  logic [VW-1:0] tbl_flt [NROWS];
  logic [31:0]   rng;
  int            value_errs;
  int            timeout_errs;

  conv_top conv_top_inst (
    .clk        (clk),
    .reset      (reset),
    .input_val  (input_val),
    .input_rdy  (input_rdy),
    .input_msg  (input_msg),
    .filter_val (filter_val),
    .filter_rdy (filter_rdy),
    .filter_msg (filter_msg),
    .output_rdy (output_rdy),
    .output_val (output_val),
    .output_msg (output_msg)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ====================
  // helpers
  // ====================

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // full product, arithmetic shift by the fraction bits, low word kept
  function automatic logic [W-1:0] ref_product(input logic [W-1:0] a, input logic [W-1:0] b);
    longint p;
    if (`CONV_SIGNED != 0) begin
      p = longint'($signed(a)) * longint'($signed(b));
    end else begin
      p = longint'(a) * longint'(b);
    end
    p = p >>> `CONV_FRAC;
    return p[W-1:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_handshake(input logic rdy_exp, input logic val_exp);
    check_value("input_rdy", 32'(rdy_exp), 32'(input_rdy));
    check_value("filter_rdy", 32'(rdy_exp), 32'(filter_rdy));
    check_value("output_val", 32'(val_exp), 32'(output_val));
  endtask

  // one valid alone must not be accepted
  task automatic hold_one_valid(input logic in_v, input logic flt_v);
    input_val  = in_v;
    filter_val = flt_v;
    repeat (5) begin
      @(negedge clk);
      check_handshake(1'b1, 1'b0);
    end
    input_val  = 1'b0;
    filter_val = 1'b0;
  endtask

  task automatic wait_for_ready();
    int n;
    n = 0;
    while (!(input_rdy && filter_rdy) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!(input_rdy && filter_rdy)) begin
      $display("timeout: input and filter readies never came back high");
      timeout_errs++;
    end
  endtask

  task automatic run_vector(input logic [VW-1:0] in_vec, input logic [VW-1:0] flt_vec,
                            input int hold);
    int            cycles;
    logic [VW-1:0] held;
    logic [W-1:0]  exp_word;
    wait_for_ready();
    input_msg  = in_vec;
    filter_msg = flt_vec;
    input_val  = 1'b1;
    filter_val = 1'b1;
    // accepting edge
    @(posedge clk);
    @(negedge clk);
    input_val  = 1'b0;
    filter_val = 1'b0;
    input_msg  = ~in_vec;
    filter_msg = ~flt_vec;
    cycles = 0;
    while (!output_val && cycles < TIMEOUT) begin
      check_handshake(1'b0, 1'b0);
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    if (!output_val) begin
      $display("timeout: output_val never rose after a vector pair was accepted");
      timeout_errs++;
      return;
    end
    if (cycles != LATENCY) begin
      $display("output_val rose %0d cycles after acceptance instead of %0d", cycles, LATENCY);
      value_errs++;
    end
    check_handshake(1'b0, 1'b1);
    for (int i = 0; i < L; i++) begin
      exp_word = ref_product(in_vec[i*W +: W], flt_vec[(L-1-i)*W +: W]);
      check_value($sformatf("output_msg[%0d]", i), 32'(exp_word), 32'(output_msg[i*W +: W]));
    end
    // back-pressure keeps everything frozen
    held = output_msg;
    repeat (hold) begin
      @(negedge clk);
      check_handshake(1'b0, 1'b1);
      if (output_msg !== held) begin
        $display("ERR output_msg: expected %h, got %h", held, output_msg);
        value_errs++;
      end
    end
    output_rdy = 1'b1;
    @(negedge clk);
    output_rdy = 1'b0;
    check_handshake(1'b1, 1'b0);
  endtask

  // ====================
  // stimulus
  // ====================

  initial begin
    logic [VW-1:0] rnd_in;
    logic [VW-1:0] rnd_flt;
    int            hold;
    reset        = 1'b1;
    input_val    = 1'b0;
    filter_val   = 1'b0;
    output_rdy   = 1'b0;
    input_msg    = '0;
    filter_msg   = '0;
    rng          = 32'h3862;
    value_errs   = 0;
    timeout_errs = 0;

    // elements packed as {e3, e2, e1, e0}
    tbl_in[0]  = '0;
    tbl_flt[0] = '0;
    tbl_in[1]  = {4{16'h0100}};
    tbl_flt[1] = {4{16'h0100}};
    tbl_in[2]  = {16'hfe80, 16'h0200, 16'hff00, 16'h0180};
    tbl_flt[2] = {16'h0100, 16'hfd00, 16'h0300, 16'hff80};
    tbl_in[3]  = {16'h8000, 16'hff80, 16'hfe00, 16'hff00};
    tbl_flt[3] = {16'hffff, 16'hfc00, 16'hff80, 16'hff00};
    tbl_in[4]  = {16'h0155, 16'h00ff, 16'h0003, 16'h0001};
    tbl_flt[4] = {16'h0033, 16'h00ff, 16'h0080, 16'h0001};
    tbl_in[5]  = {4{16'h7fff}};
    tbl_flt[5] = {4{16'hff00}};

    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_handshake(1'b1, 1'b0);

    hold_one_valid(1'b1, 1'b0);
    hold_one_valid(1'b0, 1'b1);

    for (int r = 0; r < NROWS; r++) begin
      run_vector(tbl_in[r], tbl_flt[r], 8);
    end

    for (int k = 0; k < NRAND; k++) begin
      for (int i = 0; i < L; i++) begin
        rng = xorshift(rng);
        rnd_in[i*W +: W] = rng[W-1:0];
        rnd_flt[i*W +: W] = rng[31:32-W];
      end
      rng  = xorshift(rng);
      hold = int'(rng[2:0]);
      run_vector(rnd_in, rnd_flt, hold);
    end

    $display("errors: %0d check failures, %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+rtl
rtl/fixed_pkg.sv
rtl/conv_pkg.sv
rtl/mul_if.sv
rtl/fixed_mul_iter.sv
rtl/conv_block.sv
rtl/conv_top.sv
bench/conv_tb.sv

//--- Bender.yml
package:
  name: conv_engine

sources:
  # design sources, packages first
  - include_dirs:
      - rtl
    files:
      - rtl/fixed_pkg.sv
      - rtl/conv_pkg.sv
      - rtl/mul_if.sv
      - rtl/fixed_mul_iter.sv
      - rtl/conv_block.sv
      - rtl/conv_top.sv

  # testbench
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/conv_tb.sv
